// File: atg_axi_pkg.sv
`default_nettype none

package atg_axi_pkg;

	// Datapath geometry, fixed at 64 narrow over 256 wide
	localparam int NARROW_W   = 64;             // Master side data
	localparam int WIDE_W     = 4 * NARROW_W;   // Memory port data
	localparam int LANE_W     = NARROW_W / 2;   // Interleave unit and fold width
	localparam int LANE_STRB_W = LANE_W / 8;    // Strobe bits per lane

	// AXI sideband and address widths
	localparam int ID_W       = 4;
	localparam int APP_ADDR_W = 27;             // App word address
	localparam int AXI_ADDR_W = APP_ADDR_W + 2; // Byte address

	typedef logic [NARROW_W-1:0]   narrow_data_t;
	typedef logic [WIDE_W-1:0]     wide_data_t;
	typedef logic [NARROW_W/8-1:0] narrow_strb_t;
	typedef logic [WIDE_W/8-1:0]   wide_strb_t;
	typedef logic [LANE_W-1:0]     fold_t;
	typedef logic [ID_W-1:0]       axi_id_t;
	typedef logic [1:0]            axi_resp_t;
	typedef logic [APP_ADDR_W-1:0] app_addr_t;
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

	// Narrow write beat from the master, 72 bits
	typedef struct packed {
		narrow_data_t data;
		narrow_strb_t strb;
	} wr_beat_t;

	// Widened write beat toward memory, 288 bits
	typedef struct packed {
		wide_data_t data;
		wide_strb_t strb;
	} wide_wr_beat_t;

	// Wide read beat from memory, 263 bits
	typedef struct packed {
		axi_id_t    id;
		axi_resp_t  resp;
		logic       last;
		wide_data_t data;
	} wide_rd_beat_t;

	// Narrow read beat back to the master, 71 bits
	typedef struct packed {
		axi_id_t      id;
		axi_resp_t    resp;
		logic         last;
		narrow_data_t data;
	} rd_beat_t;

endpackage

`default_nettype wire

// File: rd_capture.sv
`timescale 1ns/1ps
`default_nettype none

// First read stage. Registers the raw wide beat so the fold logic
// starts from a flop and not from the memory side pins.
module rd_capture
(
	input  wire logic                       i_clk,
	input  wire logic                       i_rst,
	input  wire atg_axi_pkg::wide_rd_beat_t i_rd,
	input  wire logic                       i_rd_valid,
	output atg_axi_pkg::wide_rd_beat_t      o_beat,
	output logic                            o_valid
);

	import atg_axi_pkg::*;

	wide_rd_beat_t beat_q; // Captured beat with sidebands
	logic          valid_q;

	always_ff @(posedge i_clk or posedge i_rst)
	begin
		if (i_rst)
		begin
			beat_q  <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			beat_q  <= i_rd; // Sampled every cycle, no stall
			valid_q <= i_rd_valid;
		end
	end

	assign o_beat  = beat_q;
	assign o_valid = valid_q;

endmodule

`default_nettype wire

// File: rd_fold.sv
`timescale 1ns/1ps
`default_nettype none

module rd_fold
(
	input  wire logic                       i_clk,
	input  wire logic                       i_rst,
	input  wire atg_axi_pkg::wide_rd_beat_t i_beat,
	input  wire logic                       i_valid,
	output atg_axi_pkg::rd_beat_t           o_beat,
	output atg_axi_pkg::fold_t              o_fold,
	output logic                            o_valid
);

	import atg_axi_pkg::*;

	narrow_data_t g0;      // Lanes 2 and 0, the narrow beat itself
	narrow_data_t g1;      // Lanes 3 and 1
	narrow_data_t g2;      // Lanes 6 and 4
	narrow_data_t g3;      // Lanes 7 and 5
	narrow_data_t xn_lo;   // Lower group pair compared
	narrow_data_t xn_hi;   // Upper group pair compared
	narrow_data_t xn_all;
	fold_t        fold_d;  // Halves of xn_all compared

	// Regroup the interleaved 32-bit lanes into 64-bit groups
	assign g0 = {i_beat.data[3*LANE_W-1:2*LANE_W], i_beat.data[LANE_W-1:0]};
	assign g1 = {i_beat.data[4*LANE_W-1:3*LANE_W], i_beat.data[2*LANE_W-1:LANE_W]};
	assign g2 = {i_beat.data[7*LANE_W-1:6*LANE_W], i_beat.data[5*LANE_W-1:4*LANE_W]};
	assign g3 = {i_beat.data[8*LANE_W-1:7*LANE_W], i_beat.data[6*LANE_W-1:5*LANE_W]};

	// XNOR tree, all ones when the four groups agree
	assign xn_lo  = ~(g1 ^ g0);
	assign xn_hi  = ~(g3 ^ g2);
	assign xn_all = ~(xn_lo ^ xn_hi);
	assign fold_d = ~(xn_all[NARROW_W-1:LANE_W] ^ xn_all[LANE_W-1:0]);

	always_ff @(posedge i_clk or posedge i_rst)
	begin
		if (i_rst)
		begin
			o_beat  <= '0;
			o_fold  <= '0;
			o_valid <= 1'b0;
		end
		else
		begin
			o_beat.id   <= i_beat.id;
			o_beat.resp <= i_beat.resp;
			o_beat.last <= i_beat.last;
			o_beat.data <= g0; // Narrow lane carried beside the fold
			o_fold      <= fold_d;
			o_valid     <= i_valid;
		end
	end

endmodule

`default_nettype wire

// File: rd_restore.sv
`timescale 1ns/1ps
`default_nettype none

module rd_restore
(
	input  wire logic                  i_clk,
	input  wire logic                  i_rst,
	input  wire atg_axi_pkg::rd_beat_t i_beat,
	input  wire atg_axi_pkg::fold_t    i_fold,
	input  wire logic                  i_valid,
	output atg_axi_pkg::rd_beat_t      o_rd,
	output logic                       o_rd_valid
);

	import atg_axi_pkg::*;

	logic         fold_same; // Every fold bit set
	narrow_data_t data_d;

	assign fold_same = &i_fold;

	// A fully matching fold marks the beat as stored inverted
	assign data_d = fold_same ? ~i_beat.data : i_beat.data;

	always_ff @(posedge i_clk or posedge i_rst)
	begin
		if (i_rst)
		begin
			o_rd       <= '0;
			o_rd_valid <= 1'b0;
		end
		else
		begin
			o_rd.id    <= i_beat.id; // Id kept with its beat
			o_rd.resp  <= i_beat.resp;
			o_rd.last  <= i_beat.last;
			o_rd.data  <= data_d;
			o_rd_valid <= i_valid;
		end
	end

endmodule

`default_nettype wire

// File: axi_width_adapter.sv
`timescale 1ns/1ps
`default_nettype none

// Width adapter between a 64-bit AXI master and a 256-bit memory port.
// Writes are widened by lane repetition with no latency, reads go through
// a three stage pipeline and come out three cycles after they arrive.
module axi_width_adapter
(
	input  wire logic                       i_clk,
	input  wire logic                       i_rst,
	input  wire atg_axi_pkg::wr_beat_t      i_wr,
	output wire atg_axi_pkg::wide_wr_beat_t o_wide_wr,
	input  wire atg_axi_pkg::app_addr_t     i_app_addr,
	output wire atg_axi_pkg::axi_addr_t     o_axi_addr,
	input  wire atg_axi_pkg::wide_rd_beat_t i_rd,
	input  wire logic                       i_rd_valid,
	output wire atg_axi_pkg::rd_beat_t      o_rd,
	output wire logic                       o_rd_valid,
	input  wire logic                       i_rready,
	output wire logic                       o_rready
);

	import atg_axi_pkg::*;

	logic [LANE_W-1:0]      wr_lo;      // Low half of narrow write data
	logic [LANE_W-1:0]      wr_hi;      // High half of narrow write data
	logic [LANE_STRB_W-1:0] strb_lo;
	logic [LANE_STRB_W-1:0] strb_hi;

	wide_rd_beat_t          cap_beat;   // Stage 0 to stage 1
	logic                   cap_valid;
	rd_beat_t               fold_beat;  // Stage 1 to stage 2
	fold_t                  fold_val;
	logic                   fold_valid;

	assign wr_lo   = i_wr.data[LANE_W-1:0];
	assign wr_hi   = i_wr.data[NARROW_W-1:LANE_W];
	assign strb_lo = i_wr.strb[LANE_STRB_W-1:0];
	assign strb_hi = i_wr.strb[2*LANE_STRB_W-1:LANE_STRB_W];

	// Lane 7 down to lane 0 is H,H,L,L,H,H,L,L
	assign o_wide_wr.data = {wr_hi, wr_hi, wr_lo, wr_lo,
	                         wr_hi, wr_hi, wr_lo, wr_lo};
	assign o_wide_wr.strb = {strb_hi, strb_hi, strb_lo, strb_lo,
	                         strb_hi, strb_hi, strb_lo, strb_lo};

	assign o_axi_addr = {i_app_addr, 2'b00}; // Word to byte address

	// Master owns back-pressure, pipeline never waits on it
	assign o_rready = i_rready;

	rd_capture u_rd_capture
	(
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_rd       (i_rd),
		.i_rd_valid (i_rd_valid),
		.o_beat     (cap_beat),
		.o_valid    (cap_valid)
	);

	rd_fold u_rd_fold
	(
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_beat  (cap_beat),
		.i_valid (cap_valid),
		.o_beat  (fold_beat),
		.o_fold  (fold_val),
		.o_valid (fold_valid)
	);

	rd_restore u_rd_restore
	(
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_beat     (fold_beat),
		.i_fold     (fold_val),
		.i_valid    (fold_valid),
		.o_rd       (o_rd),
		.o_rd_valid (o_rd_valid)
	);

endmodule

`default_nettype wire

// File: axi_width_adapter_properties.sv
`timescale 1ns/1ps
`default_nettype none

module axi_width_adapter_properties
(
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_in_valid,   // Read strobe from memory
	input wire logic i_out_valid,  // Read strobe toward the master
	input wire logic i_rready,
	input wire logic i_out_rready
);

	// Three registers between the input strobe and the output strobe
	a_rd_latency: assert property (@(posedge i_clk) disable iff (i_rst)
		i_out_valid == $past(i_in_valid, 3))
		else $error("o_rd_valid does not follow i_rd_valid by three cycles");

	a_rst_quiet: assert property (@(posedge i_clk) i_rst |-> !i_out_valid)
		else $error("o_rd_valid high while reset is asserted");

	a_rready: assert property (@(posedge i_clk) i_out_rready == i_rready)
		else $error("o_rready differs from i_rready");

endmodule

bind axi_width_adapter axi_width_adapter_properties u_properties
(
	.i_clk        (i_clk),
	.i_rst        (i_rst),
	.i_in_valid   (i_rd_valid),
	.i_out_valid  (o_rd_valid),
	.i_rready     (i_rready),
	.i_out_rready (o_rready)
);

`default_nettype wire

// File: tb_axi_width_adapter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_width_adapter;

	import atg_axi_pkg::*;

	logic          i_clk;
	logic          i_rst;
	wr_beat_t      i_wr;
	wide_wr_beat_t o_wide_wr;
	app_addr_t     i_app_addr;
	axi_addr_t     o_axi_addr;
	wide_rd_beat_t i_rd;
	logic          i_rd_valid;
	rd_beat_t      o_rd;
	logic          o_rd_valid;
	logic          i_rready;
	logic          o_rready;

	logic [31:0] lcg_state = 32'h4d97;
	int          cyc = 0;      // Rising edges since start
	int          err_cnt = 0;
	int          chk_cnt = 0;
	int          sent_cnt = 0;
	int          recv_cnt = 0;
	rd_beat_t    exp_q[$];     // Read beats still in flight
	int          due_q[$];     // Cycle on which each must come out
	rd_beat_t    mon_exp;
	int          mon_due;

	axi_width_adapter uut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	always @(posedge i_clk)
		cyc <= cyc + 1;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic wide_data_t rand_wide();
		wide_data_t d;
		int         i;
		for (i = 0; i < 8; i++)
			d[i*32 +: 32] = next_rand();
		return d;
	endfunction

	// Lanes 2,3,6,7 carry the high half, the rest the low half
	function automatic wide_wr_beat_t model_wr(input wr_beat_t w);
		wide_wr_beat_t r;
		int            i;
		for (i = 0; i < 8; i++)
		begin
			r.data[i*32 +: 32] = (i % 4 >= 2) ? w.data[63:32] : w.data[31:0];
			r.strb[i*4 +: 4]   = (i % 4 >= 2) ? w.strb[7:4] : w.strb[3:0];
		end
		return r;
	endfunction

	function automatic rd_beat_t model_rd(input wide_rd_beat_t b);
		logic [63:0] g[4];
		logic [63:0] c;
		logic [31:0] fold;
		rd_beat_t    r;
		g[0] = {b.data[64 +: 32], b.data[0 +: 32]};
		g[1] = {b.data[96 +: 32], b.data[32 +: 32]};
		g[2] = {b.data[192 +: 32], b.data[128 +: 32]};
		g[3] = {b.data[224 +: 32], b.data[160 +: 32]};
		c    = ~(~(g[1] ^ g[0]) ^ ~(g[3] ^ g[2]));
		fold = ~(c[63:32] ^ c[31:0]);
		{r.id, r.resp, r.last} = {b.id, b.resp, b.last};
		r.data = (fold == 32'hffff_ffff) ? ~g[0] : g[0];
		return r;
	endfunction

	task automatic note_err(input string name, input string exp, input string act);
		$display("ERR %s expected %s actual %s", name, exp, act);
		err_cnt++;
	endtask

	task automatic check_wide_wr(input string name, input wide_wr_beat_t exp,
		input wide_wr_beat_t act);
		chk_cnt++;
		if (exp !== act)
			note_err(name, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_addr(input string name, input axi_addr_t exp, input axi_addr_t act);
		chk_cnt++;
		if (exp !== act)
			note_err(name, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_rd(input string name, input rd_beat_t exp, input rd_beat_t act);
		chk_cnt++;
		if (exp !== act)
			note_err(name, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		chk_cnt++;
		if (exp !== act)
			note_err(name, $sformatf("%b", exp), $sformatf("%b", act));
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		chk_cnt++;
		if (exp != act)
			note_err(name, $sformatf("%0d", exp), $sformatf("%0d", act));
	endtask

	task automatic send_rd(input wide_rd_beat_t b, input rd_beat_t exp);
		i_rd       = b;
		i_rd_valid = 1'b1;
		exp_q.push_back(exp);
		due_q.push_back(cyc + 3); // Capture, fold and restore
		sent_cnt++;
	endtask

	task automatic wait_drain();
		int t;
		@(posedge i_clk);
		#1;
		i_rd_valid = 1'b0;
		t = 0;
		while (exp_q.size() != 0 && t < 20)
		begin
			@(posedge i_clk);
			t++;
		end
		if (exp_q.size() != 0)
		begin
			$display("Read pipeline timed out with %0d beats never returned", exp_q.size());
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("Test %s finished with %0d errors", name, err_cnt - errs_before);
	endtask

	// Outputs settle well before the falling edge
	always @(negedge i_clk)
	begin
		if (o_rd_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Read beat came out at cycle %0d with none outstanding", cyc);
				err_cnt++;
			end
			else
			begin
				mon_exp = exp_q.pop_front();
				mon_due = due_q.pop_front();
				check_rd("rd beat", mon_exp, o_rd);
				check_count("rd latency", mon_due, cyc);
				recv_cnt++;
			end
		end
	end

	initial
	begin
		int            i;
		int            errs;
		logic [31:0]   r;
		logic [63:0]   g;
		wr_beat_t      w;
		axi_addr_t     exp_addr;
		wide_rd_beat_t b;
		rd_beat_t      e;

		r = next_rand();
		{b.id, b.resp, b.last} = r[22:16];
		b.data = rand_wide();

		i_rst      = 1'b1;
		i_wr       = '0;
		i_app_addr = '0;
		i_rd       = b;    // Junk beat held through reset
		i_rd_valid = 1'b1; // Offered on the first reset edge only
		i_rready   = 1'b0;

		errs = err_cnt;
		repeat (4)
		begin
			@(posedge i_clk);
			#1;
			i_rd_valid = 1'b0;
			check_bit("reset rd_valid", 1'b0, o_rd_valid);
			check_rd("reset rd data", '0, o_rd);
		end
		i_rst = 1'b0;
		report_test("reset", errs);

		errs = err_cnt;
		for (i = 0; i < 200; i++)
		begin
			@(posedge i_clk);
			#1;
			r      = next_rand();
			w.data = {next_rand(), r};
			w.strb = r[27:20];
			i_wr   = w;
			@(negedge i_clk);
			check_wide_wr("write widen", model_wr(w), o_wide_wr);
		end
		report_test("write widen", errs);

		errs = err_cnt;
		for (i = 0; i < 200; i++)
		begin
			@(posedge i_clk);
			#1;
			r          = next_rand();
			i_app_addr = r[31:5];
			exp_addr   = axi_addr_t'(i_app_addr) << 2; // Four bytes per word
			@(negedge i_clk);
			check_addr("addr map", exp_addr, o_axi_addr);
		end
		report_test("addr map", errs);

		errs = err_cnt;
		for (i = 0; i < 300; i++)
		begin
			@(posedge i_clk);
			#1;
			r = next_rand();
			{b.id, b.resp, b.last} = r[22:16];
			b.data = rand_wide();
			i_rd   = b;
			if (r[29])
				send_rd(b, model_rd(b));
			else
				i_rd_valid = 1'b0; // Junk data on an idle cycle
		end
		wait_drain();
		report_test("read random", errs);

		errs = err_cnt;
		for (i = 0; i < 40; i++)
		begin
			@(posedge i_clk);
			#1;
			r = next_rand();
			g = {next_rand(), next_rand()};
			{b.id, b.resp, b.last} = r[22:16];
			b.data = {g[63:32], g[63:32], g[31:0], g[31:0], g[63:32], g[63:32], g[31:0], g[31:0]};
			{e.id, e.resp, e.last} = {b.id, b.resp, b.last};
			e.data = ~g; // Four equal groups fold to all ones
			send_rd(b, e);
		end
		wait_drain();
		report_test("read inversion", errs);

		errs = err_cnt;
		for (i = 0; i < 100; i++)
		begin
			@(posedge i_clk);
			#1;
			r         = next_rand();
			i_rready  = r[24];
			i_rd.data = rand_wide();
			@(negedge i_clk);
			check_bit("rready pass", i_rready, o_rready);
			check_bit("idle rd_valid", 1'b0, o_rd_valid);
		end
		report_test("idle and rready", errs);

		check_count("beats returned", sent_cnt, recv_cnt);
		$display("Checks %0d, errors %0d", chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
atg_axi_pkg.sv
rd_capture.sv
rd_fold.sv
rd_restore.sv
axi_width_adapter.sv
axi_width_adapter_properties.sv
tb_axi_width_adapter.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the width adapter testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_axi_width_adapter \
	-f filelist.f -o tb_axi_width_adapter
then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_axi_width_adapter > "$LOG" 2>&1
then
	cat "$LOG"
	echo "Simulation returned an error status"
	exit 1
fi

cat "$LOG"

if grep -q "^Everything OK$" "$LOG"
then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
